//--- verilog/ldpc_code_pkg.sv
// Demonstration (128,64) quasi-cyclic code only. Any other code needs new dimensions and a new table
package ldpc_code_pkg;

  // Code dimensions
  localparam int circ_size   = 16;
  localparam int circ_blocks = 4;
  localparam int info_bits   = circ_size * circ_blocks;
  localparam int parity_bits = circ_size * circ_blocks;
  localparam int code_bits   = info_bits + parity_bits;

  // Counter widths
  localparam int info_cnt_w   = $clog2(info_bits);
  localparam int parity_cnt_w = $clog2(parity_bits);
  localparam int circ_pos_w   = $clog2(circ_size);

  // One parity word, also the width of a generator row
  typedef logic [parity_bits-1:0] parity_t;

  // First row of each block row, four 16-bit circulants each
  // Block column 0 sits in the top 16 bits
  localparam parity_t circ_table [circ_blocks] = '{
    64'hB4E1_2C93_5A0F_D617,
    64'h39C6_E815_7B42_A0DD,
    64'hD05B_63AE_1F97_4C28,
    64'h6E2F_9D74_C3B8_0561
  };

endpackage

//--- verilog/ldpc_stream_pkg.sv
// Single-bit streams with valid/ready flow control. Data is only meaningful while valid is high
package ldpc_stream_pkg;

  // Upstream information bit
  typedef struct packed {
    logic data;
    logic valid;
  } bit_in_t;

  // Downstream code bit, last marks the final parity bit of a frame
  typedef struct packed {
    logic data;
    logic valid;
    logic last;
  } bit_out_t;

  // Encoder phases
  typedef enum logic [1:0] {
    wait_info   = 2'd0,
    send_info   = 2'd1,
    send_parity = 2'd2
  } enc_state_t;

endpackage

//--- verilog/ldpc_generator_rows.sv
// Steps once per information bit and wraps to block row 0 after info_bits steps
module ldpc_generator_rows
  import ldpc_code_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    row_step,
  output parity_t row,
  output logic    last_info
);

  logic [info_cnt_w-1:0]            info_cnt;
  logic [circ_pos_w-1:0]            pos;
  logic [info_cnt_w-circ_pos_w-1:0] blk;
  logic [info_cnt_w-circ_pos_w-1:0] blk_next;
  parity_t                          row_rot;

  // Low bits count rows inside a block row, high bits select the block row
  assign pos      = info_cnt[circ_pos_w-1:0];
  assign blk      = info_cnt[info_cnt_w-1:circ_pos_w];
  assign blk_next = blk + 1'b1;

  assign last_info = (info_cnt == info_cnt_w'(info_bits - 1));

  // Each circulant rotated right by one bit
  always_comb
  begin
    for (int b = 0; b < circ_blocks; b++)
    begin
      row_rot[b*circ_size +: circ_size] = {row[b*circ_size],
                                           row[b*circ_size+1 +: circ_size-1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      info_cnt <= '0;
      row      <= circ_table[0];
    end
    else if (row_step)
    begin
      info_cnt <= info_cnt + 1'b1;
      // Block boundary loads the next first row, wrapping after the last block
      if (pos == circ_pos_w'(circ_size - 1))
      begin
        row <= circ_table[blk_next];
      end
      else
      begin
        row <= row_rot;
      end
    end
  end

endmodule

//--- verilog/ldpc_parity_accum.sv
// Accumulate and shift never overlap. The controller only steps parity after the info phase
module ldpc_parity_accum
  import ldpc_code_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    row_step,
  input  logic    info_bit,
  input  parity_t row,
  input  logic    parity_step,
  output logic    parity_msb,
  output logic    last_parity
);

  parity_t                 parity;
  logic [parity_cnt_w-1:0] parity_cnt;

  assign parity_msb  = parity[parity_bits-1];
  assign last_parity = (parity_cnt == parity_cnt_w'(parity_bits - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      parity     <= '0;
      parity_cnt <= '0;
    end
    else if (parity_step)
    begin
      // Final bit taken, so start the next frame from zero
      if (last_parity)
      begin
        parity     <= '0;
        parity_cnt <= '0;
      end
      else
      begin
        parity     <= {parity[parity_bits-2:0], 1'b0};
        parity_cnt <= parity_cnt + 1'b1;
      end
    end
    else if (row_step && info_bit)
    begin
      parity <= parity ^ row;
    end
  end

endmodule

//--- verilog/ldpc_encoder_ctrl.sv
// At most one bit per two cycles in the info phase. Parity bits can go out on every cycle
module ldpc_encoder_ctrl
  import ldpc_stream_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  bit_in_t  in,
  output logic     in_ready,
  output bit_out_t out,
  input  logic     out_ready,
  input  logic     last_info,
  input  logic     parity_msb,
  input  logic     last_parity,
  output logic     row_step,
  output logic     info_bit,
  output logic     parity_step
);

  enc_state_t state;
  logic       in_xfer;
  logic       out_xfer;

  assign in_xfer  = in_ready && in.valid;
  assign out_xfer = out.valid && out_ready;

  assign row_step = (state == send_info) && out_xfer;
  assign info_bit = out.data;

  // A parity bit is taken from the accumulator whenever the output register is refilled
  assign parity_step = (state == send_parity) &&
                       (!out.valid || (out_xfer && !out.last));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= wait_info;
      in_ready <= 1'b0;
      out      <= '0;
    end
    else
    begin
      case (state)
        wait_info:
        begin
          if (in_xfer)
          begin
            in_ready  <= 1'b0;
            out.data  <= in.data;
            out.valid <= 1'b1;
            state     <= send_info;
          end
          else
          begin
            in_ready <= 1'b1;
          end
        end

        send_info:
        begin
          if (out_xfer)
          begin
            out.valid <= 1'b0;
            if (last_info)
            begin
              state <= send_parity;
            end
            else
            begin
              in_ready <= 1'b1;
              state    <= wait_info;
            end
          end
        end

        send_parity:
        begin
          if (parity_step)
          begin
            out.data  <= parity_msb;
            out.valid <= 1'b1;
            out.last  <= last_parity;
          end
          else if (out_xfer)
          begin
            // Last parity bit accepted
            out.valid <= 1'b0;
            out.last  <= 1'b0;
            in_ready  <= 1'b1;
            state     <= wait_info;
          end
        end
      endcase
    end
  end

endmodule

//--- verilog/ldpc_encoder.sv
// Systematic encoder. Each frame is 64 info bits in and 128 code bits out, last on the final bit
module ldpc_encoder
  import ldpc_code_pkg::*;
  import ldpc_stream_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  bit_in_t  in,
  output logic     in_ready,
  output bit_out_t out,
  input  logic     out_ready
);

  parity_t row;
  logic    row_step;
  logic    info_bit;
  logic    parity_step;
  logic    last_info;
  logic    parity_msb;
  logic    last_parity;

  ldpc_encoder_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .in          (in),
    .in_ready    (in_ready),
    .out         (out),
    .out_ready   (out_ready),
    .last_info   (last_info),
    .parity_msb  (parity_msb),
    .last_parity (last_parity),
    .row_step    (row_step),
    .info_bit    (info_bit),
    .parity_step (parity_step)
  );

  ldpc_generator_rows u_rows (
    .clk       (clk),
    .rst_n     (rst_n),
    .row_step  (row_step),
    .row       (row),
    .last_info (last_info)
  );

  ldpc_parity_accum u_parity (
    .clk         (clk),
    .rst_n       (rst_n),
    .row_step    (row_step),
    .info_bit    (info_bit),
    .row         (row),
    .parity_step (parity_step),
    .parity_msb  (parity_msb),
    .last_parity (last_parity)
  );

endmodule

//--- sim/ldpc_encoder_properties.sv
// Checks the encoder stream outputs only. Bound to every ldpc_encoder instance by the bind below
module ldpc_encoder_properties
  import ldpc_stream_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     in_ready,
  input bit_out_t out,
  input logic     out_ready
);

  int fail_count = 0;

  // A stalled output bit keeps its value until the sink takes it
  stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (out.valid && !out_ready) |=> (out.valid && $stable(out.data) && $stable(out.last)))
  else
  begin
    fail_count++;
    $error("Output bit changed while stalled by the sink");
  end

  last_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
    out.last |-> out.valid)
  else
  begin
    fail_count++;
    $error("Output last is high without output valid");
  end

  // Input is only accepted once the pending output bit is gone
  ready_or_valid: assert property (@(posedge clk) disable iff (!rst_n)
    !(in_ready && out.valid))
  else
  begin
    fail_count++;
    $error("in_ready and output valid are high together");
  end

endmodule

bind ldpc_encoder ldpc_encoder_properties u_properties (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_ready  (in_ready),
  .out       (out),
  .out_ready (out_ready)
);

//--- sim/ldpc_encoder_tb.sv
// Run from the project root so the golden file is found. Frames 3 to 7 are replayed with stalls
module ldpc_encoder_tb
  import ldpc_code_pkg::*;
  import ldpc_stream_pkg::*;
();

  localparam int          frame_count = 8;
  localparam int          first_mixed = 3;
  localparam int          frames_run  = frame_count + frame_count - first_mixed;
  localparam int          clk_period  = 100;
  localparam logic [31:0] lfsr_seed   = 32'h58926bdd;

  logic     clk;
  logic     rst_n;
  bit_in_t  in_bit;
  logic     in_ready;
  bit_out_t out_bit;
  logic     out_ready;

  parity_t     golden_mem [2*frame_count];
  logic [31:0] lfsr;
  int          struct_errs;
  int          test_errs;
  int          setup_errs;
  int          tests_run;
  int          tests_failed;

  ldpc_encoder u_ldpc_encoder (
    .clk       (clk),
    .rst_n     (rst_n),
    .in        (in_bit),
    .in_ready  (in_ready),
    .out       (out_bit),
    .out_ready (out_ready)
  );

  always #(clk_period/2) clk = ~clk;

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] shifted;
    shifted = state >> 1;
    if (state[0])
      shifted = shifted ^ 32'h8020_0003;
    return shifted;
  endfunction

  task automatic random_bit(output logic b);
    b    = lfsr[0];
    lfsr = lfsr_next(lfsr);
  endtask

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what, inout int errs);
    if (actual !== expected)
    begin
      $display("MISMATCH at time %0t: %s, got %0h, expected %0h",
               $time, what, actual, expected);
      errs++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs);
    tests_run++;
    if (errs == 0)
      $display("test %0d %s: passed", num, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", num, name, errs);
    end
  endtask

  // Everything is sampled and driven on the falling edge, transfers happen on the next rise
  task automatic run_frame(input int frame, input logic gaps, inout int errs);
    parity_t info;
    parity_t parity;
    int      in_idx;
    int      out_cnt;
    logic    in_taken;
    logic    stall;
    logic    exp_bit;
    info     = golden_mem[2*frame];
    parity   = golden_mem[2*frame+1];
    in_idx   = 0;
    out_cnt  = 0;
    in_taken = 1'b0;
    while (out_cnt < code_bits)
    begin
      @(negedge clk);
      if (in_taken)
      begin
        in_bit   = '0;
        in_taken = 1'b0;
      end
      if (!in_bit.valid && in_idx < info_bits)
      begin
        stall = 1'b0;
        if (gaps)
          random_bit(stall);
        if (!stall)
        begin
          in_bit.data  = info[info_bits-1-in_idx];
          in_bit.valid = 1'b1;
        end
      end
      stall = 1'b0;
      if (gaps)
        random_bit(stall);
      out_ready = !stall;
      if (in_bit.valid && in_ready)
      begin
        in_taken = 1'b1;
        in_idx++;
      end
      if (out_bit.valid && out_ready)
      begin
        if (out_cnt < info_bits)
          exp_bit = info[info_bits-1-out_cnt];
        else
          exp_bit = parity[parity_bits-1-(out_cnt-info_bits)];
        check_equal(out_bit.data, exp_bit,
                    $sformatf("frame %0d output bit %0d", frame, out_cnt), errs);
        check_equal(out_bit.last, out_cnt == code_bits - 1,
                    $sformatf("frame %0d last on bit %0d", frame, out_cnt), struct_errs);
        out_cnt++;
      end
    end
    check_equal(in_idx, info_bits, $sformatf("frame %0d info bits taken", frame), struct_errs);
  endtask

  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    in_bit       = '0;
    out_ready    = 1'b0;
    lfsr         = lfsr_seed;
    struct_errs  = 0;
    setup_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    foreach (golden_mem[i])
      golden_mem[i] = 'x;
    $readmemh("sim/ldpc_encoder_golden.hex", golden_mem);
    foreach (golden_mem[i])
      if ($isunknown(golden_mem[i]))
        setup_errs++;
    if (setup_errs != 0)
      $display("Golden file sim/ldpc_encoder_golden.hex is missing or incomplete");
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_equal(in_ready, 1'b0, "in_ready in reset", struct_errs);
    check_equal(out_bit, '0, "output in reset", struct_errs);
    rst_n = 1'b1;

    test_errs = 0;
    run_frame(0, 1'b0, test_errs);
    report_test(1, "all-zero frame", test_errs);

    test_errs = 0;
    run_frame(1, 1'b0, test_errs);
    run_frame(2, 1'b0, test_errs);
    report_test(2, "single-bit generator rows", test_errs);

    test_errs = 0;
    for (int f = first_mixed; f < frame_count; f++)
      run_frame(f, 1'b0, test_errs);
    report_test(3, "mixed frames without stalls", test_errs);

    test_errs = 0;
    for (int f = first_mixed; f < frame_count; f++)
      run_frame(f, 1'b1, test_errs);
    report_test(4, "mixed frames with random stalls", test_errs);

    // Nothing may trail the last frame
    @(negedge clk);
    in_bit    = '0;
    out_ready = 1'b1;
    repeat (4)
    begin
      @(negedge clk);
      check_equal(out_bit.valid, 1'b0, "output valid after the last frame", struct_errs);
    end
    check_equal(in_ready, 1'b1, "in_ready after the last frame", struct_errs);
    report_test(5, "frame boundaries and last", struct_errs);

    $display("%0d tests run, %0d failed, %0d assertion failures", tests_run, tests_failed,
             u_ldpc_encoder.u_properties.fail_count);
    if (tests_failed == 0 && setup_errs == 0 && u_ldpc_encoder.u_properties.fail_count == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // Generous bound of eight cycles per code bit
  initial
  begin
    #(frames_run * code_bits * 8 * clk_period);
    $display("Timeout: the encoder stopped moving bits before all frames were checked");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- sim/ldpc_encoder_golden.hex
// One 64-bit word per line: information word (bit 0 in the MSB), then its expected parity word
// Frames: all zero, bit 0, bit 17, all ones, then four mixed block patterns
0000000000000000
0000000000000000
8000000000000000
B4E12C935A0FD617
0000400000000000
1CE3F40A3DA1D06E
FFFFFFFFFFFFFFFF
000000000000FFFF
99996666EEEE1111
CCCC666666666666
5555BBBB2222DDDD
999922226666FFFF
CCCC77774444AAAA
9999999955552222
BBBB000077773333
CCCC0000AAAA0000

//--- tb.f
verilog/ldpc_code_pkg.sv
verilog/ldpc_stream_pkg.sv
verilog/ldpc_generator_rows.sv
verilog/ldpc_parity_accum.sv
verilog/ldpc_encoder_ctrl.sv
verilog/ldpc_encoder.sv
sim/ldpc_encoder_properties.sv
sim/ldpc_encoder_tb.sv
